//--- runSim.sh
#!/bin/sh
# Builds the datapath testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module dataPathTb \
    --Mdir obj_dir

./obj_dir/VdataPathTb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

//--- src.f
src/cpuPkg.sv
src/busMultiplexer.sv
src/selectEncode.sv
src/registerFile.sv
src/programRegisters.sv
src/aluUnit.sv
src/memoryInterface.sv
src/dataPath.sv
verification/dataPathTb.sv

//--- src/aluUnit.sv
`timescale 1ns/1ps
module aluUnit (
    input  logic           clock,
    input  logic           rst,
    input  logic           yIn,
    input  logic           zIn,
    input  logic           incPc,
    input  cpuPkg::aluOp_t aluOp,
    input  cpuPkg::word_t  bus,
    output cpuPkg::word_t  zValue
);

    import cpuPkg::*;

    word_t yReg;
    word_t aluResult;
    word_t zNext;

    // First operand is held in Y, second comes off the bus
    always_ff @(posedge clock) begin
        if (rst) begin
            yReg <= '0;
        end else if (yIn) begin
            yReg <= bus;
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = yReg + bus;
            aluSub:  aluResult = yReg - bus;
            aluAnd:  aluResult = yReg & bus;
            aluOr:   aluResult = yReg | bus;
            default: aluResult = '0;
        endcase
    end

    // Increment path bypasses Y entirely
    assign zNext = incPc ? bus + 32'd1 : aluResult;

    always_ff @(posedge clock) begin
        if (rst) begin
            zValue <= '0;
        end else if (zIn) begin
            zValue <= zNext;
        end
    end

    // A lone incPc would be lost since only Z captures it
    incPcNeedsZ: assert property (
        @(posedge clock) disable iff (rst) incPc |-> zIn
    ) else $error("aluUnit: incPc high without zIn");

endmodule

//--- src/busMultiplexer.sv
`timescale 1ns/1ps
module busMultiplexer (
    input  logic                clock,
    input  logic                rst,
    input  cpuPkg::busSources_t sources,
    input  cpuPkg::word_t       pc,
    input  cpuPkg::word_t       zValue,
    input  cpuPkg::word_t       mdrValue,
    input  cpuPkg::word_t       inPort,
    input  cpuPkg::word_t       cValue,
    input  cpuPkg::word_t       regValue,
    output cpuPkg::word_t       bus
);

    logic [31:0] pcMask;
    logic [31:0] zMask;
    logic [31:0] mdrMask;
    logic [31:0] inPortMask;
    logic [31:0] cMask;
    logic [31:0] regMask;

    // One mask per source, so no source wins over another
    assign pcMask     = {32{sources.pcOut}};
    assign zMask      = {32{sources.zOut}};
    assign mdrMask    = {32{sources.mdrOut}};
    assign inPortMask = {32{sources.inPortOut}};
    assign cMask      = {32{sources.cSignOut}};
    assign regMask    = {32{sources.rOut | sources.baOut}}; // R0 zeroing done in the file

    // Zero when nothing drives
    assign bus = (pcMask & pc)
               | (zMask & zValue)
               | (mdrMask & mdrValue)
               | (inPortMask & inPort)
               | (cMask & cValue)
               | (regMask & regValue);

    // A second driver would OR two words together on the bus
    singleBusDriver: assert property (
        @(posedge clock) disable iff (rst) $onehot0(sources)
    ) else $error("busMultiplexer: more than one out-strobe high");

endmodule

//--- src/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOp_t;

    // Bus drivers, at most one active per step
    typedef struct packed {
        logic pcOut;
        logic zOut;
        logic mdrOut;
        logic inPortOut;
        logic cSignOut;
        logic rOut;
        logic baOut;
    } busSources_t;

    typedef struct packed {
        logic pcIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic marIn;
        logic mdrIn;
        logic rIn;
        logic outPortIn;
    } regLoads_t;

    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
    } regSelect_t;

    // All strobes of one control step
    typedef struct packed {
        busSources_t sources;
        regLoads_t   loads;
        regSelect_t  select;
        aluOp_t      aluOp;
        logic        incPc;
        logic        read;
        logic        write;
        logic        mdRead;
    } controlWord_t;

    typedef struct packed {
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [14:0] unused;
    } regForm_t;

    typedef struct packed {
        logic [4:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [18:0] c;
    } immForm_t;

    // Same instruction word seen as register or constant format
    typedef union packed {
        regForm_t regForm;
        immForm_t immForm;
    } instruction_t;

endpackage

//--- src/dataPath.sv
`timescale 1ns/1ps
module dataPath #(
    parameter longint unsigned memDepth = 512
) (
    input  logic                 clock,
    input  logic                 rst,
    input  cpuPkg::controlWord_t control,
    input  cpuPkg::word_t        inPort,
    output cpuPkg::word_t        outPort
);

    import cpuPkg::*;

    word_t        bus;
    word_t        pc;
    word_t        zValue;
    word_t        mdrValue;
    word_t        cValue;
    word_t        regValue;
    instruction_t ir;
    logic [3:0]   regIndex;

    busMultiplexer i_busMultiplexer (
        .clock    (clock),
        .rst      (rst),
        .sources  (control.sources),
        .pc       (pc),
        .zValue   (zValue),
        .mdrValue (mdrValue),
        .inPort   (inPort),
        .cValue   (cValue),
        .regValue (regValue),
        .bus      (bus)
    );

    selectEncode i_selectEncode (
        .clock    (clock),
        .rst      (rst),
        .ir       (ir),
        .select   (control.select),
        .regIndex (regIndex),
        .cValue   (cValue)
    );

    registerFile i_registerFile (
        .clock    (clock),
        .rst      (rst),
        .regIndex (regIndex),
        .rIn      (control.loads.rIn),
        .baOut    (control.sources.baOut),
        .bus      (bus),
        .regValue (regValue)
    );

    programRegisters i_programRegisters (
        .clock (clock),
        .rst   (rst),
        .pcIn  (control.loads.pcIn),
        .irIn  (control.loads.irIn),
        .bus   (bus),
        .pc    (pc),
        .ir    (ir)
    );

    aluUnit i_aluUnit (
        .clock  (clock),
        .rst    (rst),
        .yIn    (control.loads.yIn),
        .zIn    (control.loads.zIn),
        .incPc  (control.incPc),
        .aluOp  (control.aluOp),
        .bus    (bus),
        .zValue (zValue)
    );

    memoryInterface #(
        .memDepth (memDepth)
    ) i_memoryInterface (
        .clock    (clock),
        .rst      (rst),
        .marIn    (control.loads.marIn),
        .mdrIn    (control.loads.mdrIn),
        .mdRead   (control.mdRead),
        .read     (control.read),
        .write    (control.write),
        .bus      (bus),
        .mdrValue (mdrValue)
    );

    // Output port keeps its value until the next outPortIn
    always_ff @(posedge clock) begin
        if (rst) begin
            outPort <= '0;
        end else if (control.loads.outPortIn) begin
            outPort <= bus;
        end
    end

endmodule

//--- src/memoryInterface.sv
`timescale 1ns/1ps
module memoryInterface #(
    parameter longint unsigned memDepth = 512
) (
    input  logic          clock,
    input  logic          rst,
    input  logic          marIn,
    input  logic          mdrIn,
    input  logic          mdRead,
    input  logic          read,
    input  logic          write,
    input  cpuPkg::word_t bus,
    output cpuPkg::word_t mdrValue
);

    import cpuPkg::*;

    localparam int addrWidth = (memDepth > 1) ? $clog2(memDepth) : 1;

    word_t                ram [memDepth];
    logic [addrWidth-1:0] mar;
    word_t                mdLatch;

    always_ff @(posedge clock) begin
        if (rst) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= bus[addrWidth-1:0]; // Address wraps modulo memDepth
        end
    end

    // Read data waits here until an mdRead step takes it
    always_ff @(posedge clock) begin
        if (rst) begin
            mdLatch <= '0;
        end else if (read) begin
            mdLatch <= ram[mar];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            mdrValue <= '0;
        end else if (mdrIn) begin
            mdrValue <= mdRead ? mdLatch : bus;
        end
    end

    // Contents survive reset
    always_ff @(posedge clock) begin
        if (write) begin
            ram[mar] <= mdrValue;
        end
    end

    // Both at once would hit the same MAR address in one step
    noReadWithWrite: assert property (
        @(posedge clock) disable iff (rst) !(read && write)
    ) else $error("memoryInterface: read and write high together");

endmodule

//--- src/programRegisters.sv
`timescale 1ns/1ps
module programRegisters (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 pcIn,
    input  logic                 irIn,
    input  cpuPkg::word_t        bus,
    output cpuPkg::word_t        pc,
    output cpuPkg::instruction_t ir
);

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (pcIn) begin
            pc <= bus; // Usually PC plus one from Z
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ir <= '0;
        end else if (irIn) begin
            ir <= bus; // Raw word, decoded by selectEncode
        end
    end

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ps
module registerFile (
    input  logic          clock,
    input  logic          rst,
    input  logic [3:0]    regIndex,
    input  logic          rIn,
    input  logic          baOut,
    input  cpuPkg::word_t bus,
    output cpuPkg::word_t regValue
);

    import cpuPkg::*;

    localparam int regCount = 16;

    word_t regs [regCount];
    logic  baseIsZero;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[regIndex] <= bus; // Picked by gra, grb or grc
        end
    end

    // Base address through R0 means an absolute address
    assign baseIsZero = baOut && (regIndex == 4'd0);

    assign regValue = baseIsZero ? '0 : regs[regIndex];

endmodule

//--- src/selectEncode.sv
`timescale 1ns/1ps
module selectEncode (
    input  logic                 clock,
    input  logic                 rst,
    input  cpuPkg::instruction_t ir,
    input  cpuPkg::regSelect_t   select,
    output logic [3:0]           regIndex,
    output cpuPkg::word_t        cValue
);

    logic [3:0]  raField;
    logic [3:0]  rbField;
    logic [3:0]  rcField;
    logic [18:0] cField;

    // ra and rb sit at the same bits in both formats
    assign raField = ir.regForm.ra;
    assign rbField = ir.immForm.rb;
    assign rcField = ir.regForm.rc; // Register format only
    assign cField  = ir.immForm.c;  // Constant format only

    always_comb begin
        regIndex = 4'd0;
        if (select.gra) begin
            regIndex = raField;
        end
        if (select.grb) begin
            regIndex = regIndex | rbField;
        end
        if (select.grc) begin
            regIndex = regIndex | rcField;
        end
    end

    // Sign extension of the 19-bit constant
    assign cValue = {{13{cField[18]}}, cField};

    // Field selects combine by OR, so two at once would mix indices
    oneFieldSelect: assert property (
        @(posedge clock) disable iff (rst) $onehot0(select)
    ) else $error("selectEncode: more than one of gra, grb, grc high");

endmodule

//--- verification/dataPathTb.sv
`timescale 1ns/1ps
module dataPathTb;

    import cpuPkg::*;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 8;
    localparam int memDepth    = 512;
    localparam int loadOffset  = -5; // Negative constant for the based load

    typedef struct packed {
        aluOp_t aluOp;
        logic   incPc;
        logic   read;
        logic   write;
        logic   mdRead;
    } stepExtra_t;

    typedef struct packed {
        controlWord_t control;
        word_t        inValue;
        logic         check;
        word_t        expected;
    } step_t;

    // Single strobes, combined per step
    localparam busSources_t srcNone = '0;
    localparam busSources_t srcPc   = '{pcOut: 1'b1, default: 1'b0};
    localparam busSources_t srcZ    = '{zOut: 1'b1, default: 1'b0};
    localparam busSources_t srcMdr  = '{mdrOut: 1'b1, default: 1'b0};
    localparam busSources_t srcIn   = '{inPortOut: 1'b1, default: 1'b0};
    localparam busSources_t srcC    = '{cSignOut: 1'b1, default: 1'b0};
    localparam busSources_t srcR    = '{rOut: 1'b1, default: 1'b0};
    localparam busSources_t srcBa   = '{baOut: 1'b1, default: 1'b0};
    localparam regLoads_t   ldNone  = '0;
    localparam regLoads_t   ldPc    = '{pcIn: 1'b1, default: 1'b0};
    localparam regLoads_t   ldIr    = '{irIn: 1'b1, default: 1'b0};
    localparam regLoads_t   ldY     = '{yIn: 1'b1, default: 1'b0};
    localparam regLoads_t   ldZ     = '{zIn: 1'b1, default: 1'b0};
    localparam regLoads_t   ldMar   = '{marIn: 1'b1, default: 1'b0};
    localparam regLoads_t   ldMdr   = '{mdrIn: 1'b1, default: 1'b0};
    localparam regLoads_t   ldR     = '{rIn: 1'b1, default: 1'b0};
    localparam regLoads_t   ldOut   = '{outPortIn: 1'b1, default: 1'b0};
    localparam regSelect_t  selNone = '0;
    localparam regSelect_t  selA    = '{gra: 1'b1, default: 1'b0};
    localparam regSelect_t  selB    = '{grb: 1'b1, default: 1'b0};
    localparam regSelect_t  selC    = '{grc: 1'b1, default: 1'b0};
    localparam stepExtra_t  exNone   = '{aluOp: aluAdd, default: 1'b0};
    localparam stepExtra_t  exSub    = '{aluOp: aluSub, default: 1'b0};
    localparam stepExtra_t  exInc    = '{aluOp: aluAdd, incPc: 1'b1, default: 1'b0};
    localparam stepExtra_t  exRead   = '{aluOp: aluAdd, read: 1'b1, default: 1'b0};
    localparam stepExtra_t  exWrite  = '{aluOp: aluAdd, write: 1'b1, default: 1'b0};
    localparam stepExtra_t  exMdRead = '{aluOp: aluAdd, mdRead: 1'b1, default: 1'b0};

    logic         clock;
    logic         rst;
    controlWord_t control;
    word_t        inPort;
    word_t        outPort;
    step_t        steps[$];
    word_t        memAddr[4];
    word_t        memData[4];
    word_t        loadBase;
    word_t        opA;
    word_t        opB;
    word_t        pcStart;
    int           errorCount;
    int           checkCount;
    logic         tableReady;

    dataPath #(
        .memDepth (memDepth)
    ) i_dut (
        .clock   (clock),
        .rst     (rst),
        .control (control),
        .inPort  (inPort),
        .outPort (outPort)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic checkValue(input word_t actual, input word_t expected, input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic addStep(input busSources_t src, input regLoads_t ld, input regSelect_t sel,
                           input stepExtra_t ex, input word_t value = '0,
                           input logic check = 1'b0, input word_t expected = '0);
        step_t row;
        row.control.sources = src;
        row.control.loads   = ld;
        row.control.select  = sel;
        row.control.aluOp   = ex.aluOp;
        row.control.incPc   = ex.incPc;
        row.control.read    = ex.read;
        row.control.write   = ex.write;
        row.control.mdRead  = ex.mdRead;
        row.inValue         = value;
        row.check           = check;
        row.expected        = expected;
        steps.push_back(row);
    endtask

    function automatic word_t regInstr(input logic [3:0] ra, input logic [3:0] rb,
                                       input logic [3:0] rc);
        return {5'd3, ra, rb, rc, 15'd0}; // add ra, rb, rc
    endfunction

    function automatic word_t immInstr(input logic [3:0] ra, input logic [3:0] rb,
                                       input logic [18:0] c);
        return {5'd0, ra, rb, c}; // ld ra, c(rb)
    endfunction

    task automatic storeWord(input word_t addr, input word_t data);
        addStep(srcIn, ldMdr, selNone, exNone, data);
        addStep(srcIn, ldMar, selNone, exNone, addr);
        addStep(srcNone, ldNone, selNone, exWrite);
    endtask

    task automatic readWord(input word_t addr, input word_t expected);
        addStep(srcIn, ldMar, selNone, exNone, addr);
        addStep(srcNone, ldNone, selNone, exRead);
        addStep(srcNone, ldMdr, selNone, exMdRead);
        addStep(srcMdr, ldOut, selNone, exNone, '0, 1'b1, expected);
    endtask

    // ld ra, c(rb) as base plus constant, then ra shown on outPort
    task automatic loadSequence(input word_t expected);
        addStep(srcBa, ldY, selB, exNone);
        addStep(srcC, ldZ, selNone, exNone);
        addStep(srcZ, ldMar, selNone, exNone);
        addStep(srcNone, ldNone, selNone, exRead);
        addStep(srcNone, ldMdr, selNone, exMdRead);
        addStep(srcMdr, ldR, selA, exNone);
        addStep(srcR, ldOut, selA, exNone, '0, 1'b1, expected);
    endtask

    task automatic buildTable();
        addStep(srcIn, ldIr, selNone, exNone, regInstr(4'd5, 4'd0, 4'd0));
        // All ones first, so the zero from R5 has to arrive
        addStep(srcIn, ldOut, selNone, exNone, 32'hFFFF_FFFF, 1'b1, 32'hFFFF_FFFF);
        addStep(srcR, ldOut, selA, exNone, '0, 1'b1, '0); // R5 cleared by reset
        for (int k = 0; k < 4; k++) begin
            storeWord(memAddr[k], memData[k]);
        end
        for (int k = 0; k < 4; k++) begin
            readWord(memAddr[k], memData[k]);
        end
        addStep(srcIn, ldIr, selNone, exNone, immInstr(4'd2, 4'd0, memAddr[2][18:0]));
        addStep(srcIn, ldR, selB, exNone, loadBase); // R0 nonzero, baOut hides it
        loadSequence(memData[2]);
        addStep(srcIn, ldIr, selNone, exNone, immInstr(4'd2, 4'd1, 19'(loadOffset)));
        addStep(srcIn, ldR, selB, exNone, loadBase); // R1 holds the base
        loadSequence(memData[3]);
        addStep(srcIn, ldIr, selNone, exNone, regInstr(4'd3, 4'd1, 4'd2));
        addStep(srcIn, ldR, selB, exNone, opA);
        addStep(srcIn, ldR, selC, exNone, opB);
        addStep(srcR, ldY, selB, exNone);
        addStep(srcR, ldZ, selC, exNone);
        addStep(srcZ, ldR, selA, exNone);
        addStep(srcR, ldOut, selA, exNone, '0, 1'b1, opA + opB);
        addStep(srcR, ldZ, selC, exSub); // Y still holds R1
        addStep(srcZ, ldOut, selNone, exNone, '0, 1'b1, opA - opB);
        addStep(srcIn, ldPc, selNone, exNone, pcStart);
        addStep(srcPc, ldZ, selNone, exInc);
        addStep(srcZ, ldPc, selNone, exNone);
        addStep(srcPc, ldOut, selNone, exNone, '0, 1'b1, pcStart + 32'd1);
    endtask

    initial begin
        void'($urandom(92));
        rst        = 1'b1;
        control    = '0;
        inPort     = '0;
        errorCount = 0;
        checkCount = 0;
        tableReady = 1'b0;
        for (int k = 0; k < 4; k++) begin
            memData[k] = $urandom();
        end
        loadBase   = {23'($urandom()), 9'h105}; // Base minus five lands at 0x100
        memAddr[0] = 32'h010;
        memAddr[1] = 32'h011;
        memAddr[2] = 32'h020;
        memAddr[3] = (loadBase + 32'(loadOffset)) & 32'(memDepth - 1); // MAR wraps
        opA        = $urandom();
        opB        = $urandom();
        pcStart    = $urandom();
        buildTable();
        tableReady = 1'b1;

        repeat (resetCycles) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        checkValue(outPort, '0, "outPort after reset");

        // Row i is driven while row i-1's outPort load becomes visible
        for (int i = 0; i <= steps.size(); i++) begin
            @(posedge clock);
            if (i < steps.size()) begin
                control <= steps[i].control;
                inPort  <= steps[i].inValue;
            end else begin
                control <= '0;
                inPort  <= '0;
            end
            @(negedge clock);
            if (i > 0 && steps[i-1].check) begin
                checkValue(outPort, steps[i-1].expected,
                           $sformatf("outPort after step %0d", i - 1));
            end
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Table length plus reset and a margin
    initial begin
        wait (tableReady);
        #((steps.size() + resetCycles + 20) * clockPeriod);
        $display("Watchdog: the step table did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule
